// File: csr_defs.svh
// CSR addresses follow the RV32 privileged spec numbering
// Only machine-mode registers and the counter shadows are listed
// Top two address bits both set marks a read-only CSR

`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

////////////////////////////////////////
// Machine trap setup and handling
////////////////////////////////////////
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

////////////////////////////////////////
// Counters
////////////////////////////////////////
// Machine copies, writable
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MCYCLEH     12'hB80
`define CSR_MINSTRETH   12'hB82
// User copies, read-only
`define CSR_CYCLE       12'hC00
`define CSR_INSTRET     12'hC02
`define CSR_CYCLEH      12'hC80
`define CSR_INSTRETH    12'hC82

// MIE is bit 3, MPIE is bit 7
`define CSR_MSTATUS_WMASK   32'h0000_0088
// Trap vector after reset, direct mode
`define CSR_MTVEC_RESET     32'h0000_0100

`endif

// File: csr_pkg.sv
// Types shared by the CSR execute block
// Field widths are fixed by the RV32 Zicsr encoding

package csr_pkg;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // funct3 field of the SYSTEM opcode
    typedef enum logic [2:0] {
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } csr_funct3_e;

    // Read-modify-write flavour
    typedef enum logic [1:0] {
        CSR_OP_RW  = 2'b00,
        CSR_OP_SET = 2'b01,
        CSR_OP_CLR = 2'b10
    } csr_op_e;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Request from the pipeline, fields already split out
    typedef struct packed {
        logic        valid;
        csr_funct3_e funct3;
        logic [11:0] addr;
        // rs1 index or uimm, depending on funct3
        logic [4:0]  src_idx;
        logic [31:0] rs1_data;
    } csr_req_t;

    // Decoded command into the unit
    typedef struct packed {
        logic        valid;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] operand;
        logic        wr_en;
    } csr_cmd_t;

    // Response, one cycle after the request
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
        logic        illegal;
    } csr_rsp_t;

    // Software write into the counters
    typedef struct packed {
        logic        cycle_lo;
        logic        cycle_hi;
        logic        instret_lo;
        logic        instret_hi;
        logic [31:0] wdata;
    } cnt_wr_t;

endpackage

// File: csr_op_decoder.sv
// Purely combinational, no state
// Unknown funct3 values yield a command with no write

module csr_op_decoder (
    input  csr_pkg::csr_req_t req_i,
    output csr_pkg::csr_cmd_t cmd_o
);

    import csr_pkg::*;

    // Immediate forms take the uimm instead of rs1
    logic imm_form;
    // Source of x0 or uimm 0
    logic src_zero;

    assign imm_form = (req_i.funct3 inside {F3_CSRRWI, F3_CSRRSI, F3_CSRRCI});
    assign src_zero = (req_i.src_idx == 5'd0);

    ////////////////////////////////////////
    // Command build
    ////////////////////////////////////////
    always_comb begin
        // Pass-through fields
        cmd_o.valid = req_i.valid;
        cmd_o.addr  = req_i.addr;

        // Zero-extended uimm for immediate forms
        if (imm_form) begin
            cmd_o.operand = {27'd0, req_i.src_idx};
        end else begin
            cmd_o.operand = req_i.rs1_data;
        end

        // Defaults cover unknown funct3
        cmd_o.op    = CSR_OP_RW;
        cmd_o.wr_en = 1'b0;

        case (req_i.funct3)
            F3_CSRRW, F3_CSRRWI: begin
                // Swap always writes
                cmd_o.op    = CSR_OP_RW;
                cmd_o.wr_en = 1'b1;
            end
            F3_CSRRS, F3_CSRRSI: begin
                // x0 or uimm 0 means read only
                cmd_o.op    = CSR_OP_SET;
                cmd_o.wr_en = !src_zero;
            end
            F3_CSRRC, F3_CSRRCI: begin
                cmd_o.op    = CSR_OP_CLR;
                cmd_o.wr_en = !src_zero;
            end
            default: begin
                cmd_o.op    = CSR_OP_RW;
                cmd_o.wr_en = 1'b0;
            end
        endcase
    end

endmodule

// File: csr_counters.sv
// Free-running 64-bit cycle and instret counters
// A software write to either half wins over the increment at that edge
// No overflow flag, both wrap silently

module csr_counters (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             retire_i,
    input  csr_pkg::cnt_wr_t wr_i,
    output logic [63:0]      cycle_o,
    output logic [63:0]      instret_o
);

    logic [63:0] cycle_q;
    logic [63:0] instret_q;

    // Next count, shared by both counters
    function automatic logic [63:0] cnt_next(
        input logic [63:0] cur,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] wdata,
        input logic        inc
    );
        logic [63:0] nxt;
        nxt = cur;
        if (wr_lo || wr_hi) begin
            // Write replaces only the strobed half
            if (wr_lo) begin
                nxt[31:0] = wdata;
            end
            if (wr_hi) begin
                nxt[63:32] = wdata;
            end
        end else if (inc) begin
            nxt = cur + 64'd1;
        end
        return nxt;
    endfunction

    ////////////////////////////////////////
    // Counter registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            // Cycle counts every edge
            cycle_q   <= cnt_next(cycle_q, wr_i.cycle_lo, wr_i.cycle_hi,
                                  wr_i.wdata, 1'b1);
            // Instret counts retired instructions only
            instret_q <= cnt_next(instret_q, wr_i.instret_lo, wr_i.instret_hi,
                                  wr_i.wdata, retire_i);
        end
    end

    assign cycle_o   = cycle_q;
    assign instret_o = instret_q;

endmodule

// File: csr_unit.sv
// Machine-mode CSR file with a fixed one-cycle response
// rdata is the value before the write; illegal accesses return 0
// Only MIE/MPIE of mstatus are kept, mtvec and mepc are word aligned

`include "csr_defs.svh"

module csr_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    input  csr_pkg::csr_cmd_t cmd_i,
    input  logic [63:0]       cycle_i,
    input  logic [63:0]       instret_i,
    output csr_pkg::cnt_wr_t  cnt_wr_o,
    output csr_pkg::csr_rsp_t rsp_o
);

    import csr_pkg::*;

    // Machine CSRs
    logic [31:0] mstatus_q;
    logic [31:0] mscratch_q;
    logic [31:0] mtvec_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;

    // Access decode
    logic [31:0] rd_val;
    logic        known;
    logic        read_only;
    logic        illegal;
    logic        do_write;
    logic [31:0] wr_val;

    // Response registers
    logic        rsp_valid_q;
    logic        rsp_illegal_q;
    logic [31:0] rsp_rdata_q;

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        rd_val = '0;
        known  = 1'b1;
        case (cmd_i.addr)
            `CSR_MSTATUS:   rd_val = mstatus_q & `CSR_MSTATUS_WMASK;
            `CSR_MSCRATCH:  rd_val = mscratch_q;
            `CSR_MTVEC:     rd_val = mtvec_q;
            `CSR_MEPC:      rd_val = mepc_q;
            `CSR_MCAUSE:    rd_val = mcause_q;
            // Machine and user views share the same counter
            `CSR_MCYCLE,
            `CSR_CYCLE:     rd_val = cycle_i[31:0];
            `CSR_MCYCLEH,
            `CSR_CYCLEH:    rd_val = cycle_i[63:32];
            `CSR_MINSTRET,
            `CSR_INSTRET:   rd_val = instret_i[31:0];
            `CSR_MINSTRETH,
            `CSR_INSTRETH:  rd_val = instret_i[63:32];
            default: begin
                rd_val = '0;
                known  = 1'b0;
            end
        endcase
    end

    // Top two address bits set means read-only space
    assign read_only = (cmd_i.addr[11:10] == 2'b11);
    assign illegal   = !known || (read_only && cmd_i.wr_en);
    assign do_write  = cmd_i.valid && cmd_i.wr_en && !illegal;

    ////////////////////////////////////////
    // Read-modify-write
    ////////////////////////////////////////
    always_comb begin
        case (cmd_i.op)
            CSR_OP_RW:  wr_val = cmd_i.operand;
            CSR_OP_SET: wr_val = rd_val | cmd_i.operand;
            CSR_OP_CLR: wr_val = rd_val & ~cmd_i.operand;
            default:    wr_val = rd_val;
        endcase
    end

    // Counter halves are written inside csr_counters
    assign cnt_wr_o.cycle_lo   = do_write && (cmd_i.addr == `CSR_MCYCLE);
    assign cnt_wr_o.cycle_hi   = do_write && (cmd_i.addr == `CSR_MCYCLEH);
    assign cnt_wr_o.instret_lo = do_write && (cmd_i.addr == `CSR_MINSTRET);
    assign cnt_wr_o.instret_hi = do_write && (cmd_i.addr == `CSR_MINSTRETH);
    assign cnt_wr_o.wdata      = wr_val;

    ////////////////////////////////////////
    // Register file update
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_q  <= '0;
            mscratch_q <= '0;
            mtvec_q    <= `CSR_MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (do_write) begin
            case (cmd_i.addr)
                // WARL, only MIE and MPIE stick
                `CSR_MSTATUS:  mstatus_q  <= wr_val & `CSR_MSTATUS_WMASK;
                `CSR_MSCRATCH: mscratch_q <= wr_val;
                // Low two bits hardwired to zero
                `CSR_MTVEC:    mtvec_q    <= {wr_val[31:2], 2'b00};
                `CSR_MEPC:     mepc_q     <= {wr_val[31:2], 2'b00};
                `CSR_MCAUSE:   mcause_q   <= wr_val;
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q   <= 1'b0;
            rsp_illegal_q <= 1'b0;
        end else begin
            rsp_valid_q   <= cmd_i.valid;
            rsp_illegal_q <= cmd_i.valid && illegal;
        end
    end

    // Data path, zero on illegal access
    always_ff @(posedge clk_i) begin
        rsp_rdata_q <= illegal ? 32'd0 : rd_val;
    end

    assign rsp_o.valid   = rsp_valid_q;
    assign rsp_o.rdata   = rsp_rdata_q;
    assign rsp_o.illegal = rsp_illegal_q;

endmodule

// File: csr_subsystem.sv
// Zicsr execute block top level
// One request per cycle, no ready, response exactly one cycle later
// retire_i pulses once per retired instruction

module csr_subsystem (
    input  logic              clk_i,
    input  logic              rst_i,
    input  csr_pkg::csr_req_t req_i,
    input  logic              retire_i,
    output csr_pkg::csr_rsp_t rsp_o
);

    import csr_pkg::*;

    // Decoder to unit
    csr_cmd_t    cmd;
    // Unit to counters
    cnt_wr_t     cnt_wr;
    // Counters back to unit
    logic [63:0] cycle;
    logic [63:0] instret;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////
    csr_op_decoder u_decoder (
        .req_i (req_i),
        .cmd_o (cmd)
    );

    ////////////////////////////////////////
    // CSR file and response
    ////////////////////////////////////////
    csr_unit u_unit (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .cmd_i     (cmd),
        .cycle_i   (cycle),
        .instret_i (instret),
        .cnt_wr_o  (cnt_wr),
        .rsp_o     (rsp_o)
    );

    ////////////////////////////////////////
    // Counters
    ////////////////////////////////////////
    csr_counters u_counters (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .retire_i  (retire_i),
        .wr_i      (cnt_wr),
        .cycle_o   (cycle),
        .instret_o (instret)
    );

endmodule

// File: tb_csr_subsystem.sv
// Directed tests of the CSR execute block against a shadow model in the testbench
// Inputs change and responses are sampled 1 ns after the rising edge
// Counter values stay small and carries into the high halves are not exercised

`include "csr_defs.svh"

module tb_csr_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    // Whole run is under 150 cycles and the limit leaves a wide margin
    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] SEED           = 32'h2994_a8a1;

    logic     clk_i = 1'b0;
    logic     rst_i;
    logic     retire_i;
    csr_req_t req;
    csr_rsp_t rsp;

    // Shadow CSRs
    logic [31:0] sh_mstatus;
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mepc;
    logic [31:0] sh_mcause;
    // Shadow counters, value at the start of the current cycle
    logic [63:0] cyc_model;
    logic [63:0] inst_model;

    // Bookkeeping
    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          errors_at_start;
    int          cycle_count  = 0;
    int          seed_val;
    logic [31:0] last_rdata;

    csr_subsystem DUT (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (req),
        .retire_i (retire_i),
        .rsp_o    (rsp)
    );

    // 8 ns period
    always #4 clk_i = ~clk_i;

    // Watchdog
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // One edge with the shadow counters advancing alongside
    task automatic tick();
        logic ret;
        ret = retire_i;
        @(posedge clk_i);
        #1;
        cyc_model = cyc_model + 64'd1;
        if (ret) begin
            inst_model = inst_model + 64'd1;
        end
    endtask

    task automatic idle(input int n);
        req.valid = 1'b0;
        repeat (n) tick();
    endtask

    function automatic logic [4:0] nonzero_idx();
        logic [31:0] r;
        r = $urandom();
        return r[4:0] | 5'd1;
    endfunction

    // Issue one request and check the response one cycle later against the shadows
    task automatic access(input string name, input csr_funct3_e f3,
                          input logic [11:0] addr, input logic [4:0] idx,
                          input logic [31:0] rs1);
        logic        imm;
        logic        wr;
        logic        known;
        logic        illegal;
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] nxt;
        logic [31:0] exp_rdata;
        logic [63:0] cyc_pre;
        logic [63:0] inst_pre;
        imm     = (f3 == F3_CSRRWI) || (f3 == F3_CSRRSI) || (f3 == F3_CSRRCI);
        operand = imm ? {27'd0, idx} : rs1;
        // Swaps always write while set and clear need a nonzero source
        wr      = (f3 == F3_CSRRW) || (f3 == F3_CSRRWI) || (idx != 5'd0);
        known   = 1'b1;
        case (addr)
            `CSR_MSTATUS:                 old = sh_mstatus;
            `CSR_MSCRATCH:                old = sh_mscratch;
            `CSR_MTVEC:                   old = sh_mtvec;
            `CSR_MEPC:                    old = sh_mepc;
            `CSR_MCAUSE:                  old = sh_mcause;
            `CSR_MCYCLE, `CSR_CYCLE:      old = cyc_model[31:0];
            `CSR_MCYCLEH, `CSR_CYCLEH:    old = cyc_model[63:32];
            `CSR_MINSTRET, `CSR_INSTRET:  old = inst_model[31:0];
            `CSR_MINSTRETH, `CSR_INSTRETH: old = inst_model[63:32];
            default: begin
                old   = 32'd0;
                known = 1'b0;
            end
        endcase
        illegal   = !known || ((addr[11:10] == 2'b11) && wr);
        exp_rdata = illegal ? 32'd0 : old;
        case (f3)
            F3_CSRRW, F3_CSRRWI: nxt = operand;
            F3_CSRRS, F3_CSRRSI: nxt = old | operand;
            default:             nxt = old & ~operand;
        endcase
        cyc_pre  = cyc_model;
        inst_pre = inst_model;

        req.valid    = 1'b1;
        req.funct3   = f3;
        req.addr     = addr;
        req.src_idx  = idx;
        req.rs1_data = rs1;
        tick();
        req.valid = 1'b0;

        // Write lands at the edge just passed and replaces the increment
        if (wr && !illegal) begin
            case (addr)
                `CSR_MSTATUS:   sh_mstatus  = nxt & `CSR_MSTATUS_WMASK;
                `CSR_MSCRATCH:  sh_mscratch = nxt;
                `CSR_MTVEC:     sh_mtvec    = {nxt[31:2], 2'b00};
                `CSR_MEPC:      sh_mepc     = {nxt[31:2], 2'b00};
                `CSR_MCAUSE:    sh_mcause   = nxt;
                `CSR_MCYCLE:    cyc_model   = {cyc_pre[63:32], nxt};
                `CSR_MCYCLEH:   cyc_model   = {nxt, cyc_pre[31:0]};
                `CSR_MINSTRET:  inst_model  = {inst_pre[63:32], nxt};
                `CSR_MINSTRETH: inst_model  = {nxt, inst_pre[31:0]};
                default: begin
                end
            endcase
        end

        checks = checks + 3;
        if (rsp.valid !== 1'b1) begin
            errors = errors + 1;
            $display("%s: no valid response one cycle after the request", name);
        end
        if (rsp.illegal !== illegal) begin
            errors = errors + 1;
            $display("** Error %s: illegal expected %0b, actual %0b", name, illegal,
                     rsp.illegal);
        end
        if (rsp.rdata !== exp_rdata) begin
            errors = errors + 1;
            $display("** Error %s: rdata expected 0x%08h, actual 0x%08h", name, exp_rdata,
                     rsp.rdata);
        end
        last_rdata = rsp.rdata;
    endtask

    // Direct check of a value against a constant from the CSR rules
    task automatic expect_word(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (errors == errors_at_start) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %s: failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_values();
        begin_test();
        checks = checks + 1;
        if (rsp.valid !== 1'b0) begin
            errors = errors + 1;
            $display("reset_values: response valid high right after reset");
        end
        access("reset_values", F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'd0);
        access("reset_values", F3_CSRRS, `CSR_MEPC, 5'd0, 32'd0);
        access("reset_values", F3_CSRRS, `CSR_MCAUSE, 5'd0, 32'd0);
        access("reset_values", F3_CSRRS, `CSR_MSTATUS, 5'd0, 32'd0);
        access("reset_values", F3_CSRRS, `CSR_MTVEC, 5'd0, 32'd0);
        expect_word("reset_values", `CSR_MTVEC_RESET, last_rdata);
        // No request, so no response
        idle(1);
        checks = checks + 1;
        if (rsp.valid !== 1'b0) begin
            errors = errors + 1;
            $display("reset_values: response valid high without a request");
        end
        end_test("reset_values");
    endtask

    // Every form on mscratch issued back to back
    task automatic test_mscratch_forms();
        logic [31:0] r;
        begin_test();
        repeat (4) begin
            r = $urandom();
            access("mscratch_forms", F3_CSRRW, `CSR_MSCRATCH, nonzero_idx(), r);
            r = $urandom();
            access("mscratch_forms", F3_CSRRS, `CSR_MSCRATCH, nonzero_idx(), r);
            r = $urandom();
            access("mscratch_forms", F3_CSRRC, `CSR_MSCRATCH, nonzero_idx(), r);
            access("mscratch_forms", F3_CSRRWI, `CSR_MSCRATCH, nonzero_idx(), 32'd0);
            access("mscratch_forms", F3_CSRRSI, `CSR_MSCRATCH, nonzero_idx(), 32'd0);
            access("mscratch_forms", F3_CSRRCI, `CSR_MSCRATCH, nonzero_idx(), 32'd0);
            // Index zero must block the write even with all-ones data
            access("mscratch_forms", F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF);
            access("mscratch_forms", F3_CSRRC, `CSR_MSCRATCH, 5'd0, 32'hFFFF_FFFF);
            access("mscratch_forms", F3_CSRRCI, `CSR_MSCRATCH, 5'd0, 32'd0);
        end
        end_test("mscratch_forms");
    endtask

    task automatic test_warl();
        begin_test();
        access("warl", F3_CSRRW, `CSR_MSTATUS, 5'd1, 32'hFFFF_FFFF);
        access("warl", F3_CSRRS, `CSR_MSTATUS, 5'd0, 32'd0);
        expect_word("warl", 32'h0000_0088, last_rdata);
        access("warl", F3_CSRRW, `CSR_MTVEC, 5'd1, 32'hFFFF_FFFF);
        access("warl", F3_CSRRS, `CSR_MTVEC, 5'd0, 32'd0);
        expect_word("warl", 32'hFFFF_FFFC, last_rdata);
        access("warl", F3_CSRRW, `CSR_MEPC, 5'd1, 32'hFFFF_FFFF);
        access("warl", F3_CSRRS, `CSR_MEPC, 5'd0, 32'd0);
        expect_word("warl", 32'hFFFF_FFFC, last_rdata);
        end_test("warl");
    endtask

    task automatic test_counters();
        logic [31:0] first;
        logic [31:0] r;
        logic [31:0] v;
        int          retired;
        begin_test();
        // Reads 7 cycles apart
        access("counters", F3_CSRRS, `CSR_CYCLE, 5'd0, 32'd0);
        first = last_rdata;
        idle(6);
        access("counters", F3_CSRRS, `CSR_CYCLE, 5'd0, 32'd0);
        expect_word("counters", 32'd7, last_rdata - first);

        // Random retire pattern
        access("counters", F3_CSRRS, `CSR_INSTRET, 5'd0, 32'd0);
        first   = last_rdata;
        retired = 0;
        repeat (12) begin
            r        = $urandom();
            retire_i = r[0];
            if (r[0]) begin
                retired = retired + 1;
            end
            tick();
        end
        retire_i = 1'b0;
        access("counters", F3_CSRRS, `CSR_INSTRET, 5'd0, 32'd0);
        expect_word("counters", retired, last_rdata - first);

        // mcycle write followed by 5 idle edges
        r = $urandom();
        v = {16'd0, r[15:0]};
        access("counters", F3_CSRRW, `CSR_MCYCLE, 5'd3, v);
        idle(5);
        access("counters", F3_CSRRS, `CSR_MCYCLE, 5'd0, 32'd0);
        expect_word("counters", v + 32'd5, last_rdata);

        // High half written through the machine address and read through the user view
        r = $urandom();
        access("counters", F3_CSRRW, `CSR_MCYCLEH, 5'd4, r);
        access("counters", F3_CSRRS, `CSR_CYCLEH, 5'd0, 32'd0);
        expect_word("counters", r, last_rdata);
        end_test("counters");
    endtask

    task automatic test_illegal();
        logic [31:0] first;
        logic [31:0] r;
        begin_test();
        access("illegal", F3_CSRRS, 12'h7C0, 5'd0, 32'd0);
        expect_word("illegal", 32'd1, {31'd0, rsp.illegal});
        r = $urandom();
        access("illegal", F3_CSRRW, 12'h7C0, 5'd5, r);
        // Unknown address write leaves mscratch alone
        access("illegal", F3_CSRRS, `CSR_MSCRATCH, 5'd0, 32'd0);

        // Write to a read-only counter
        access("illegal", F3_CSRRS, `CSR_CYCLE, 5'd0, 32'd0);
        first = last_rdata;
        expect_word("illegal", 32'd0, {31'd0, rsp.illegal});
        r = $urandom();
        access("illegal", F3_CSRRW, `CSR_CYCLE, 5'd6, r);
        expect_word("illegal", 32'd1, {31'd0, rsp.illegal});
        access("illegal", F3_CSRRS, `CSR_CYCLE, 5'd0, 32'd0);
        expect_word("illegal", 32'd0, {31'd0, rsp.illegal});
        expect_word("illegal", 32'd2, last_rdata - first);

        // Immediate form with uimm 0 on a read-only counter is still a plain read
        access("illegal", F3_CSRRCI, `CSR_CYCLE, 5'd0, 32'd0);
        end_test("illegal");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        rst_i    = 1'b1;
        retire_i = 1'b0;
        req      = '0;
        seed_val = $urandom(SEED);

        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Post-reset state
        sh_mstatus  = 32'd0;
        sh_mscratch = 32'd0;
        sh_mtvec    = `CSR_MTVEC_RESET;
        sh_mepc     = 32'd0;
        sh_mcause   = 32'd0;
        cyc_model   = 64'd0;
        inst_model  = 64'd0;

        test_reset_values();
        test_mscratch_forms();
        test_warl();
        test_counters();
        test_illegal();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+.
csr_pkg.sv
csr_op_decoder.sv
csr_counters.sv
csr_unit.sv
csr_subsystem.sv
tb_csr_subsystem.sv

// File: Makefile
# Verilator build and run for the CSR execute block
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_csr_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= >>> PASS

SRCS := $(wildcard *.sv) $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F -- '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
